// File: design/isa_pkg.sv
package isa_pkg;

    // datapath widths
    localparam int ISA_WIDTH     = 32;      // data and word address width
    localparam int REG_IDX_WIDTH = 5;       // 32 general registers

    // decoded operation, one per issued instruction
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,                     // rd = rs + rt
        OP_SUB  = 4'd1,                     // rd = rs - rt
        OP_AND  = 4'd2,                     // rd = rs & rt
        OP_OR   = 4'd3,                     // rd = rs | rt
        OP_XOR  = 4'd4,                     // rd = rs ^ rt
        OP_SLT  = 4'd5,                     // rd = signed rs < rt
        OP_ADDI = 4'd6,                     // rd = rs + imm
        OP_LW   = 4'd7,                     // rd = mem[rs + imm]
        OP_SW   = 4'd8,                     // mem[rs + imm] = rt
        OP_LINK = 4'd9                      // r31 = pc + 4
    } alu_op_t;

    // 2-bit memory control carried down the pipe
    localparam int MEM_WRITE_BIT = 1;       // store to data memory
    localparam int MEM_READ_BIT  = 0;       // load from data memory

    // return address register written by link
    localparam logic [REG_IDX_WIDTH-1:0] LINK_REG = 5'd31;

endpackage

// File: design/fwd_pkg.sv
package fwd_pkg;

    // where an operand or the store data comes from
    typedef enum logic [1:0] {
        FWD_INPUT   = 2'd0,                 // value read from general_reg
        FWD_MEM_RES = 2'd1,                 // alu result of the instruction in mem
        FWD_WB_RES  = 2'd2                  // data being written back
    } fwd_sel_t;

    // hazard vector seen by the ex/mem stage register
    localparam int HAZD_WIDTH     = 1;
    localparam int HAZD_NO_OP_BIT = 0;      // bubble, nothing issued this cycle

endpackage

// File: design/pipe_stage_if.sv
`timescale 1ns/1ns

interface pipe_stage_if;
    import isa_pkg::*;

    logic                     no_op;        // bubble marker
    logic [ISA_WIDTH-1:0]     pc_4;         // return address for link
    logic                     reg_write;    // instruction writes a register
    logic [1:0]               mem_control;  // [MEM_WRITE_BIT] store, [MEM_READ_BIT] load
    logic [ISA_WIDTH-1:0]     alu_result;   // result, or word address for lw/sw
    logic [ISA_WIDTH-1:0]     store_data;   // rt value for sw
    logic [REG_IDX_WIDTH-1:0] dest_reg;     // destination register index

    // producing stage
    modport src (
        output no_op, pc_4, reg_write, mem_control,
        output alu_result, store_data, dest_reg
    );

    // consuming stage
    modport dst (
        input  no_op, pc_4, reg_write, mem_control,
        input  alu_result, store_data, dest_reg
    );

    // forwarding view from execute
    modport peek (
        input  dest_reg, reg_write, mem_control, alu_result
    );

endinterface

// File: design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                              clk,               // sampled by the assertion only
    input  logic                              rst_n,
    input  logic                              issue,             // decoded instruction valid
    input  isa_pkg::alu_op_t                  op,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rt,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rd,
    input  logic [15:0]                       imm,
    input  logic [isa_pkg::ISA_WIDTH-1:0]     pc_4,
    input  logic [isa_pkg::ISA_WIDTH-1:0]     rs_data,           // from general_reg
    input  logic [isa_pkg::ISA_WIDTH-1:0]     rt_data,
    pipe_stage_if.peek                        mem_bus,           // instruction one ahead
    input  logic                              wb_valid,          // instruction two ahead
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] wb_dest_reg,
    input  logic [isa_pkg::ISA_WIDTH-1:0]     wb_data,
    output fwd_pkg::fwd_sel_t                 store_data_select, // resolved in ex_mem_reg
    pipe_stage_if.src                         ex_bus
);
    import isa_pkg::*;
    import fwd_pkg::*;

    fwd_sel_t                 rs_sel;
    fwd_sel_t                 rt_sel;
    logic [ISA_WIDTH-1:0]     op_a;                              // forwarded rs
    logic [ISA_WIDTH-1:0]     rt_fwd;                            // forwarded rt
    logic [ISA_WIDTH-1:0]     op_b;
    logic [ISA_WIDTH-1:0]     imm_ext;
    logic [ISA_WIDTH-1:0]     alu_out;
    logic [REG_IDX_WIDTH-1:0] dest;
    logic [HAZD_WIDTH-1:0]    hazard;
    logic                     uses_rs;
    logic                     uses_rt;
    logic                     uses_imm;

    // mem stage wins over writeback, r0 is never forwarded
    function automatic fwd_sel_t pick_src(input logic [REG_IDX_WIDTH-1:0] src);
        if (src == '0)
            return FWD_INPUT;
        if (mem_bus.reg_write && mem_bus.dest_reg == src)
            return FWD_MEM_RES;
        if (wb_valid && wb_dest_reg == src)
            return FWD_WB_RES;
        return FWD_INPUT;
    endfunction

    function automatic logic [ISA_WIDTH-1:0] fwd_value(input fwd_sel_t sel,
                                                       input logic [ISA_WIDTH-1:0] reg_val);
        case (sel)
            FWD_MEM_RES: return mem_bus.alu_result;
            FWD_WB_RES:  return wb_data;
            default:     return reg_val;
        endcase
    endfunction

    assign rs_sel            = pick_src(rs);
    assign rt_sel            = pick_src(rt);
    assign op_a              = fwd_value(rs_sel, rs_data);
    assign rt_fwd            = fwd_value(rt_sel, rt_data);
    assign store_data_select = rt_sel;                           // same rule for sw data

    assign imm_ext  = {{(ISA_WIDTH - 16){imm[15]}}, imm};        // sign extend
    assign uses_imm = (op == OP_ADDI) || (op == OP_LW) || (op == OP_SW);
    assign uses_rs  = (op != OP_LINK);
    assign uses_rt  = !uses_imm && (op != OP_LINK) || (op == OP_SW);
    assign op_b     = uses_imm ? imm_ext : rt_fwd;

    always_comb begin
        case (op)
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_SLT:  alu_out = {{(ISA_WIDTH - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            OP_LINK: alu_out = pc_4;                             // lets mem stage forward it
            default: alu_out = op_a + op_b;                      // add, addi, lw/sw word address
        endcase
    end

    assign dest = (op == OP_LINK) ? LINK_REG : rd;

    always_comb begin
        hazard                 = '0;
        hazard[HAZD_NO_OP_BIT] = ~issue;                         // no issue means bubble
    end

    assign ex_bus.no_op      = hazard[HAZD_NO_OP_BIT];
    assign ex_bus.pc_4       = pc_4;
    assign ex_bus.reg_write  = issue && (op != OP_SW) && (dest != '0);
    assign ex_bus.alu_result = alu_out;
    assign ex_bus.store_data = rt_data;                          // unforwarded, fixed up later
    assign ex_bus.dest_reg   = dest;

    always_comb begin
        ex_bus.mem_control                = '0;
        ex_bus.mem_control[MEM_READ_BIT]  = issue && (op == OP_LW);
        ex_bus.mem_control[MEM_WRITE_BIT] = issue && (op == OP_SW);
    end

    // the issuer leaves a gap after a load, its data is not ready for forwarding
    a_no_load_use: assert property (@(posedge clk) disable iff (!rst_n)
        issue && mem_bus.reg_write && mem_bus.mem_control[MEM_READ_BIT] |->
            !(uses_rs && rs == mem_bus.dest_reg) && !(uses_rt && rt == mem_bus.dest_reg));

endmodule

// File: design/ex_mem_reg.sv
`timescale 1ns/1ns

module ex_mem_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    pipe_stage_if.dst                     ex_bus,            // from execute
    input  fwd_pkg::fwd_sel_t             store_data_select, // from execute forwarding
    input  logic [isa_pkg::ISA_WIDTH-1:0] wb_data,           // writeback value
    pipe_stage_if.src                     mem_bus            // to mem stage
);
    import isa_pkg::*;
    import fwd_pkg::*;

    logic [HAZD_WIDTH-1:0] hazard_in;
    logic [ISA_WIDTH-1:0]  store_next;

    always_comb begin
        hazard_in                 = '0;
        hazard_in[HAZD_NO_OP_BIT] = ex_bus.no_op;
    end

    // sw data from rt, the instruction now in mem, or the one in writeback
    always_comb begin
        case (store_data_select)
            FWD_MEM_RES: store_next = mem_bus.alu_result;    // our own previous result
            FWD_WB_RES:  store_next = wb_data;
            default:     store_next = ex_bus.store_data;
        endcase
    end

    // control, cleared to a bubble on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_bus.no_op       <= 1'b1;
            mem_bus.reg_write   <= 1'b0;
            mem_bus.mem_control <= '0;
        end else begin
            mem_bus.no_op       <= hazard_in[HAZD_NO_OP_BIT];
            mem_bus.reg_write   <= ex_bus.reg_write;
            mem_bus.mem_control <= ex_bus.mem_control;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        mem_bus.pc_4       <= ex_bus.pc_4;
        mem_bus.alu_result <= ex_bus.alu_result;
        mem_bus.store_data <= store_next;
        mem_bus.dest_reg   <= ex_bus.dest_reg;
    end

    // one memory access per instruction
    a_mem_ctrl_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_bus.mem_control[MEM_WRITE_BIT] && mem_bus.mem_control[MEM_READ_BIT]));

endmodule

// File: design/general_reg.sv
`timescale 1ns/1ns

module general_reg (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs,          // read port a
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rt,          // read port b
    output logic [isa_pkg::ISA_WIDTH-1:0]     rs_data,
    output logic [isa_pkg::ISA_WIDTH-1:0]     rt_data,
    input  logic                              wb_valid,    // write port
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] wb_dest_reg,
    input  logic [isa_pkg::ISA_WIDTH-1:0]     wb_data
);
    import isa_pkg::*;

    localparam int NUM_REGS = 2 ** REG_IDX_WIDTH;

    logic [ISA_WIDTH-1:0] regs [NUM_REGS];

    // combinational reads, same-cycle writes come in through forwarding
    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                             // all registers read zero
            end
        end else if (wb_valid && wb_dest_reg != '0) begin
            regs[wb_dest_reg] <= wb_data;                  // r0 stays zero
        end
    end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/1ns

module mem_stage #(
    parameter int DMEM_DEPTH = 256                             // data memory words
) (
    input  logic                              clk,
    input  logic                              rst_n,
    pipe_stage_if.dst                         mem_bus,         // from ex_mem_reg
    output logic                              wb_valid,        // writeback register
    output logic [isa_pkg::REG_IDX_WIDTH-1:0] wb_dest_reg,
    output logic [isa_pkg::ISA_WIDTH-1:0]     wb_data
);
    import isa_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [ISA_WIDTH-1:0] dmem [DMEM_DEPTH];                   // word addressed
    logic [DMEM_AW-1:0]   word_idx;
    logic [ISA_WIDTH-1:0] rd_word;
    logic [ISA_WIDTH-1:0] result;
    logic                 is_load;
    logic                 is_store;

    assign word_idx = mem_bus.alu_result[DMEM_AW-1:0];
    assign is_load  = mem_bus.mem_control[MEM_READ_BIT];
    assign is_store = mem_bus.mem_control[MEM_WRITE_BIT] && !mem_bus.no_op;

    assign rd_word = dmem[word_idx];                           // asynchronous read

    always_ff @(posedge clk) begin
        if (is_store) begin
            dmem[word_idx] <= mem_bus.store_data;
        end
    end

    always_comb begin
        if (is_load)
            result = rd_word;
        else
            result = mem_bus.alu_result;                       // link already carries pc + 4
    end

    // mem/wb stage register, valid cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_bus.reg_write && !mem_bus.no_op;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest_reg <= mem_bus.dest_reg;
        wb_data     <= result;
    end

    // lw/sw word addresses come from execute and must land inside the memory
    a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_bus.no_op && mem_bus.mem_control != '0 |->
            mem_bus.alu_result < DMEM_DEPTH);

endmodule

// File: design/ex_mem_top.sv
`timescale 1ns/1ns

module ex_mem_top #(
    parameter int DMEM_DEPTH = 256                             // data memory words
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              issue,           // one-cycle strobe
    input  isa_pkg::alu_op_t                  op,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rt,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rd,
    input  logic [15:0]                       imm,
    input  logic [isa_pkg::ISA_WIDTH-1:0]     pc_4,
    output logic                              wb_valid,        // two cycles after issue
    output logic [isa_pkg::REG_IDX_WIDTH-1:0] wb_dest_reg,
    output logic [isa_pkg::ISA_WIDTH-1:0]     wb_data
);
    import isa_pkg::*;
    import fwd_pkg::*;

    logic [ISA_WIDTH-1:0] rs_data;
    logic [ISA_WIDTH-1:0] rt_data;
    fwd_sel_t             store_data_select;

    pipe_stage_if ex_bus ();                                   // execute to stage register
    pipe_stage_if mem_bus ();                                  // stage register to mem

    general_reg u_general_reg (
        .clk, .rst_n, .rs, .rt, .rs_data, .rt_data,
        .wb_valid, .wb_dest_reg, .wb_data
    );

    execute_stage u_execute_stage (
        .clk, .rst_n, .issue, .op, .rs, .rt, .rd, .imm, .pc_4,
        .rs_data, .rt_data, .mem_bus(mem_bus.peek),
        .wb_valid, .wb_dest_reg, .wb_data,
        .store_data_select, .ex_bus(ex_bus.src)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk, .rst_n, .ex_bus(ex_bus.dst), .store_data_select,
        .wb_data, .mem_bus(mem_bus.src)
    );

    mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem_stage (
        .clk, .rst_n, .mem_bus(mem_bus.dst),
        .wb_valid, .wb_dest_reg, .wb_data
    );

endmodule

// File: sim/tb_ex_mem.sv
`timescale 1ns/1ns

module tb_ex_mem;
    import isa_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 400;
    localparam int DIRECTED_MAX = 100;                   // directed part plus memory fill, bound
    // every instruction may be followed by a bubble
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 2 * (DIRECTED_MAX + NUM_RANDOM)) * CLK_PERIOD + 200;

    typedef struct packed {
        logic [REG_IDX_WIDTH-1:0] dest;
        logic [ISA_WIDTH-1:0]     data;
        logic [31:0]              cycle;                 // cycle in which wb_valid is due
    } expect_t;

    logic                     clk;
    logic                     rst_n;
    logic                     issue;
    alu_op_t                  op;
    logic [REG_IDX_WIDTH-1:0] rs;
    logic [REG_IDX_WIDTH-1:0] rt;
    logic [REG_IDX_WIDTH-1:0] rd;
    logic [15:0]              imm;
    logic [ISA_WIDTH-1:0]     pc_4;
    logic                     wb_valid;
    logic [REG_IDX_WIDTH-1:0] wb_dest_reg;
    logic [ISA_WIDTH-1:0]     wb_data;

    logic [15:0]          lfsr = 16'd34837;              // stimulus generator state
    logic [ISA_WIDTH-1:0] mregs [32];                    // model register file
    logic [ISA_WIDTH-1:0] mmem [16];                     // model of the 16-word window
    expect_t              exp_q [$];                     // pending register writes, in order
    logic [31:0]          cycle_cnt = '0;
    logic [ISA_WIDTH-1:0] next_pc = 32'h0040_0004;
    logic                 load_pending = 1'b0;           // last issued was a load with rd != 0
    int                   load_dest = 0;
    int                   n_issued = 0;
    int                   n_checked = 0;

    ex_mem_top #(.DMEM_DEPTH(256)) DUT (
        .clk, .rst_n, .issue, .op, .rs, .rt, .rd, .imm, .pc_4,
        .wb_valid, .wb_dest_reg, .wb_data
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

    // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic bit reads_rs(input alu_op_t f_op);
        return f_op != OP_LINK;
    endfunction

    function automatic bit reads_rt(input alu_op_t f_op);
        return f_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SW};
    endfunction

    // architectural model, one call per issued instruction
    function automatic void predict_result(input alu_op_t p_op,
                                           input logic [REG_IDX_WIDTH-1:0] p_rs,
                                           input logic [REG_IDX_WIDTH-1:0] p_rt,
                                           input logic [REG_IDX_WIDTH-1:0] p_rd,
                                           input logic [15:0] p_imm,
                                           input logic [ISA_WIDTH-1:0] p_pc4);
        logic [ISA_WIDTH-1:0]     a;
        logic [ISA_WIDTH-1:0]     b;
        logic [ISA_WIDTH-1:0]     imm_ext;
        logic [ISA_WIDTH-1:0]     addr;
        logic [ISA_WIDTH-1:0]     res;
        logic [REG_IDX_WIDTH-1:0] dest;
        logic                     writes;
        expect_t                  e;
        a       = mregs[p_rs];                           // r0 is kept at zero
        b       = mregs[p_rt];
        imm_ext = {{16{p_imm[15]}}, p_imm};
        addr    = a + imm_ext;                           // word address for lw/sw
        dest    = p_rd;
        writes  = 1'b1;
        res     = '0;
        case (p_op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = a + imm_ext;
            OP_LW:   res = mmem[addr[3:0]];
            OP_SW: begin
                mmem[addr[3:0]] = b;
                writes          = 1'b0;                  // stores write no register
            end
            default: begin
                dest = LINK_REG;                         // link
                res  = p_pc4;
            end
        endcase
        if (writes && dest != '0) begin
            mregs[dest] = res;
            e.dest      = dest;
            e.data      = res;
            e.cycle     = cycle_cnt + 32'd2;             // fixed two-cycle latency
            exp_q.push_back(e);
        end
    endfunction

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checked++;
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic send_bubble();
        @(posedge clk);
        #1;
        issue        = 1'b0;
        load_pending = 1'b0;
    endtask

    task automatic send_instr(input alu_op_t i_op, input int i_rs, input int i_rt,
                              input int i_rd, input int i_imm);
        if (load_pending &&
            ((reads_rs(i_op) && i_rs == load_dest) || (reads_rt(i_op) && i_rt == load_dest))) begin
            send_bubble();                               // load data not forwardable yet
        end
        @(posedge clk);
        #1;
        issue = 1'b1;
        op    = i_op;
        rs    = 5'(i_rs);
        rt    = 5'(i_rt);
        rd    = 5'(i_rd);
        imm   = 16'(i_imm);
        pc_4  = next_pc;
        predict_result(op, rs, rt, rd, imm, pc_4);
        next_pc      = next_pc + 32'd4;
        load_pending = (i_op == OP_LW) && (i_rd != 0);
        load_dest    = i_rd;
        n_issued++;
    endtask

    task automatic run_directed();
        send_instr(OP_ADDI, 0, 0, 1, 5);                 // independent ops
        send_instr(OP_ADDI, 0, 0, 2, -3);
        send_instr(OP_ADDI, 0, 0, 3, 'h1234);
        send_instr(OP_ADDI, 0, 0, 4, 'h7fff);
        send_instr(OP_ADDI, 0, 0, 5, -32768);
        send_instr(OP_ADD, 1, 2, 6, 0);
        send_instr(OP_SUB, 3, 4, 7, 0);
        send_instr(OP_AND, 3, 4, 1, 0);
        send_instr(OP_OR, 5, 3, 2, 0);
        send_instr(OP_XOR, 4, 5, 3, 0);
        send_instr(OP_SLT, 5, 6, 4, 0);                  // negative < positive
        send_instr(OP_SLT, 6, 5, 7, 0);
        send_instr(OP_ADDI, 0, 0, 1, 100);               // dependency chain
        send_instr(OP_ADDI, 0, 0, 1, 200);
        send_instr(OP_ADD, 1, 1, 2, 0);                  // mem stage beats writeback
        send_instr(OP_SUB, 2, 1, 3, 0);
        send_instr(OP_XOR, 3, 2, 4, 0);
        send_instr(OP_ADDI, 4, 0, 4, 1);
        send_instr(OP_OR, 4, 3, 5, 0);
        send_instr(OP_SLT, 5, 4, 6, 0);
        send_instr(OP_ADDI, 0, 0, 1, 3);                 // store then load
        send_instr(OP_ADDI, 0, 0, 2, 'h55);
        send_instr(OP_SW, 1, 2, 0, 0);                   // data one back, base two back
        send_instr(OP_LW, 1, 0, 3, 0);
        send_instr(OP_ADD, 3, 0, 4, 0);                  // gets a bubble first
        send_instr(OP_ADDI, 0, 0, 5, 'h66);
        send_instr(OP_ADDI, 0, 0, 6, 9);
        send_instr(OP_SW, 6, 5, 0, -2);                  // data two back
        send_instr(OP_LW, 0, 0, 7, 7);
        send_instr(OP_SW, 0, 7, 0, 8);                   // loaded word as store data
        send_instr(OP_LW, 6, 0, 1, -1);
        send_instr(OP_LINK, 0, 0, 0, 0);
        send_instr(OP_SW, 0, 31, 0, 10);                 // link result as store data
        send_instr(OP_LW, 0, 0, 2, 10);
        send_instr(OP_LINK, 0, 0, 5, 0);                 // r31 readers
        send_instr(OP_ADD, 31, 0, 1, 0);
        send_instr(OP_ADD, 31, 31, 2, 0);
        send_instr(OP_ADDI, 0, 0, 3, 1);
        send_instr(OP_OR, 31, 3, 4, 0);
        send_instr(OP_ADDI, 0, 0, 31, 'h77);             // plain alu write to r31
        send_instr(OP_ADD, 31, 0, 5, 0);
        send_instr(OP_ADD, 1, 2, 0, 0);                  // r0 writes and reads
        send_instr(OP_ADDI, 0, 0, 0, 9);
        send_instr(OP_ADD, 0, 1, 3, 0);
        send_instr(OP_OR, 0, 0, 4, 0);
        send_instr(OP_SW, 0, 0, 0, 11);
        send_instr(OP_LW, 0, 0, 5, 11);
        send_instr(OP_SLT, 0, 5, 6, 0);
    endtask

    // every word of the window gets a value before random loads
    task automatic fill_memory();
        for (int k = 0; k < 16; k++) begin
            send_instr(OP_ADDI, 0, 0, k % 7 + 1, k * 4099 + 7);
            send_instr(OP_SW, 0, k % 7 + 1, 0, k);
        end
    endtask

    task automatic run_random(input int count);
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] diff;
        alu_op_t     r_op;
        int          r_rs;
        int          r_rt;
        int          r_rd;
        int          r_imm;
        for (int n = 0; n < count; n++) begin
            rnd   = take_bits(4) % 10;
            r_op  = alu_op_t'(rnd[3:0]);
            r_rs  = int'(take_bits(3));                  // r0..r7, many dependencies
            r_rt  = int'(take_bits(3));
            r_rd  = int'(take_bits(3));
            r_imm = int'(take_bits(16));
            if (r_op == OP_LW || r_op == OP_SW) begin
                addr = take_bits(4);                     // 16-word window
                diff = addr - mregs[r_rs];
                if ($signed(diff) >= -32768 && $signed(diff) <= 32767) begin
                    r_imm = int'(diff);
                end else begin
                    r_rs  = 0;                           // base too far off
                    r_imm = int'(addr);
                end
            end
            send_instr(r_op, r_rs, r_rt, r_rd, r_imm);
        end
    endtask

    // compare writebacks at the falling edge, outputs settled
    always @(negedge clk) begin
        expect_t e;
        if (!rst_n) begin
            check_value("wb_valid", 32'd0, {31'd0, wb_valid});
        end else if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("wb_valid high in cycle %0d with no register write expected",
                         cycle_cnt);
                stop_with_failure();
            end else begin
                e = exp_q.pop_front();
                check_value("wb_dest_reg", {27'd0, e.dest}, {27'd0, wb_dest_reg});
                check_value("wb_data", e.data, wb_data);
                check_value("wb_cycle", e.cycle, cycle_cnt);
            end
        end else begin
            check_value("wb_valid", 32'd0, {31'd0, wb_valid});  // also catches x
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, run did not end within %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        issue = 1'b0;
        op    = OP_ADD;
        rs    = '0;
        rt    = '0;
        rd    = '0;
        imm   = '0;
        pc_4  = '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_directed();
        fill_memory();
        run_random(NUM_RANDOM);
        send_bubble();
        repeat (4) @(posedge clk);                       // drain the two-stage pipe
        if (exp_q.size() != 0) begin
            $display("%0d expected register writes never appeared", exp_q.size());
            stop_with_failure();
        end else begin
            $display("%0d instructions issued, %0d checks", n_issued, n_checked);
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: ex_mem_slice.f
design/isa_pkg.sv
design/fwd_pkg.sv
design/pipe_stage_if.sv
design/execute_stage.sv
design/ex_mem_reg.sv
design/general_reg.sv
design/mem_stage.sv
design/ex_mem_top.sv
sim/tb_ex_mem.sv

// File: Makefile
TOP = tb_ex_mem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f ex_mem_slice.f --top-module $(TOP) -Mdir obj_dir

# pass only if the testbench printed its pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
